// ==== src.f ====
+incdir+include
design/cache_addr_pkg.sv
design/cache_state_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_ctrl.sv
design/main_memory.sv
design/cache_top.sv
verification/tb_clock_gen.sv
verification/cache_tb.sv

// ==== Bender.yml ====
package:
  name: assoc_cache

export_include_dirs:
  - include

sources:
  - design/cache_addr_pkg.sv
  - design/cache_state_pkg.sv
  - design/cache_tag_store.sv
  - design/cache_data_store.sv
  - design/cache_ctrl.sv
  - design/main_memory.sv
  - design/cache_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/cache_tb.sv

// ==== verification/cache_tb.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_tb
    import cache_addr_pkg::*;
();

    localparam int COLD_PAIRS   = 8;
    localparam int WR_ROUNDS    = 4;
    localparam int LRU_TAGS     = 5;
    localparam int RANDOM_COUNT = 300;
    localparam int NUM_REQUESTS = 2 * COLD_PAIRS + 3 * WR_ROUNDS + 2 * LRU_TAGS
                                  + 2 * `BLOCK_WORDS + `CACHE_WAYS + RANDOM_COUNT;
    localparam int CYCLE_LIMIT  = NUM_REQUESTS * 20 + 200;

    logic   clk;
    logic   reset;
    logic   rden;
    logic   wren;
    addr_t  addr;
    word_t  data_in;
    logic   busy;
    logic   done;
    logic   hit;
    word_t  data_out;

    integer seed = 32'hdd28;
    int     cycle_count = 0;
    int     req_count = 0;
    int     done_count = 0;
    int     pass_checks = 0;
    int     fail_checks = 0;
    int     test_errors = 0;
    int     test_requests = 0;
    int     proto_errors = 0;

    // model memory image and per-set tag lists with the newest tag first
    word_t  mem_image [`MEM_WORDS];
    tag_t   lru_tag   [`CACHE_SETS][`CACHE_WAYS];
    int     lru_fill  [`CACHE_SETS];

    tb_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cache_top UUT (
        .clk      (clk),
        .reset    (reset),
        .rden     (rden),
        .wren     (wren),
        .addr     (addr),
        .data_in  (data_in),
        .busy     (busy),
        .done     (done),
        .hit      (hit),
        .data_out (data_out)
    );

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    // counts done pulses for the final protocol check
    always @(negedge clk)
    begin
        if (!reset && done)
            done_count++;
    end

    task automatic log_mismatch(input string test_name, input string what,
                                input word_t expected, input word_t actual);
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        fail_checks++;
        test_errors++;
    endtask

    task automatic protocol_error(input string what);
        $display("protocol error: %s at cycle %0d", what, cycle_count);
        fail_checks++;
        proto_errors++;
    endtask

    // true LRU per set with slot 0 the newest
    // a miss on a full set drops the oldest tag
    task automatic model_access(input addr_t a, output logic was_hit);
        index_t s;
        tag_t   t;
        int     pos;
        int     i;
        s   = a[`OFFSET_W +: `INDEX_W];
        t   = a[`ADDR_W-1 -: `TAG_W];
        pos = -1;
        for (i = 0; i < lru_fill[s]; i++)
        begin
            if (lru_tag[s][i] == t)
                pos = i;
        end
        was_hit = (pos >= 0);
        if (!was_hit)
        begin
            if (lru_fill[s] < `CACHE_WAYS)
                lru_fill[s]++;
            pos = lru_fill[s] - 1;
        end
        for (i = pos; i > 0; i--)
            lru_tag[s][i] = lru_tag[s][i-1];
        lru_tag[s][0] = t;
    endtask

    task automatic do_request(input string test_name, input logic is_write,
                              input addr_t a, input word_t d);
        logic  exp_hit;
        word_t exp_data;
        int    latency;
        model_access(a, exp_hit);
        if (is_write)
            mem_image[a] = d;
        exp_data = mem_image[a];

        @(posedge clk);
        #1;
        if (busy)
            protocol_error("busy is high before a new strobe");
        rden    = !is_write;
        wren    = is_write;
        addr    = a;
        data_in = d;
        req_count++;
        test_requests++;
        @(posedge clk);
        #1;
        rden = 1'b0;
        wren = 1'b0;

        latency = 0;
        do
        begin
            @(negedge clk);
            latency++;
            if (!done && !busy)
                protocol_error("busy is low while a request is pending");
        end
        while (!done);

        if (busy)
            protocol_error("busy is high in the done cycle");
        if (hit !== exp_hit)
            log_mismatch(test_name, "hit", exp_hit, hit);
        else
            pass_checks++;
        if (data_out !== exp_data)
            log_mismatch(test_name, "data_out", exp_data, data_out);
        else
            pass_checks++;
        if (exp_hit)
        begin
            if (latency != 2)
                log_mismatch(test_name, "hit latency", 2, latency);
            else
                pass_checks++;
        end
    endtask

    task automatic summarize_test(input string test_name);
        $display("test %-12s requests %0d, errors %0d", test_name, test_requests, test_errors);
        test_requests = 0;
        test_errors   = 0;
    endtask

    task automatic cold_reads();
        addr_t a;
        int    i;
        for (i = 0; i < COLD_PAIRS; i++)
        begin
            a = $random(seed);
            do_request("cold_read", 1'b0, a, '0);
            // neighbour word in the block just filled
            a[`OFFSET_W-1:0] = a[`OFFSET_W-1:0] + 1'b1;
            do_request("cold_read", 1'b0, a, '0);
        end
        summarize_test("cold_read");
    endtask

    task automatic write_then_read();
        addr_t a;
        word_t d;
        int    i;
        for (i = 0; i < WR_ROUNDS; i++)
        begin
            a = $random(seed);
            d = $random(seed);
            do_request("write_read", 1'b1, a, d);
            do_request("write_read", 1'b0, a, '0);
            a[`OFFSET_W-1:0] = a[`OFFSET_W-1:0] + 1'b1;
            do_request("write_read", 1'b0, a, '0);
        end
        summarize_test("write_read");
    endtask

    task automatic lru_eviction();
        tag_t   base;
        index_t s;
        int     i;
        base = $random(seed);
        s    = $random(seed);
        for (i = 0; i < LRU_TAGS; i++)
            do_request("lru_evict", 1'b0, {tag_t'(base + i), s, offset_t'(i)}, '0);
        // re-read newest first so only the first tag misses
        for (i = LRU_TAGS - 1; i >= 0; i--)
            do_request("lru_evict", 1'b0, {tag_t'(base + i), s, offset_t'(i)}, '0);
        summarize_test("lru_evict");
    endtask

    task automatic dirty_write_back();
        tag_t   base;
        index_t s;
        word_t  d;
        int     i;
        base = $random(seed);
        s    = $random(seed);
        for (i = 0; i < `BLOCK_WORDS; i++)
        begin
            d = $random(seed);
            do_request("write_back", 1'b1, {base, s, offset_t'(i)}, d);
        end
        // enough other tags in the set to push the dirty block out
        for (i = 1; i <= `CACHE_WAYS; i++)
            do_request("write_back", 1'b0, {tag_t'(base + i), s, offset_t'(0)}, '0);
        for (i = 0; i < `BLOCK_WORDS; i++)
            do_request("write_back", 1'b0, {base, s, offset_t'(i)}, '0);
        summarize_test("write_back");
    endtask

    task automatic random_traffic();
        logic       is_write;
        logic [5:0] blk;
        offset_t    off;
        word_t      d;
        int         i;
        for (i = 0; i < RANDOM_COUNT; i++)
        begin
            is_write = $random(seed);
            blk      = $random(seed);
            off      = $random(seed);
            d        = $random(seed);
            // 64 blocks made of 16 tags in each of the 4 sets
            do_request("random_mix", is_write, {4'b0000, blk, off}, d);
        end
        summarize_test("random_mix");
    endtask

    initial
    begin
        int k;
        rden    = 1'b0;
        wren    = 1'b0;
        addr    = '0;
        data_in = '0;
        for (k = 0; k < `MEM_WORDS; k++)
            mem_image[k] = '0;
        for (k = 0; k < `CACHE_SETS; k++)
            lru_fill[k] = 0;

        @(negedge reset);
        @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0)
            protocol_error("busy or done is not low after reset");

        cold_reads();
        write_then_read();
        lru_eviction();
        dirty_write_back();
        random_traffic();

        // let the last done pulse reach the counter
        @(posedge clk);
        if (done_count != req_count)
            protocol_error("number of done pulses differs from number of requests");
        $display("test %-12s requests %0d, errors %0d", "protocol", req_count, proto_errors);

        $display("checks passed %0d, failed %0d", pass_checks, fail_checks);
        if (fail_checks == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 10 rising edges, released just after an edge
    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== design/cache_top.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_top
    import cache_addr_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rden,
    input  logic  wren,
    input  addr_t addr,
    input  word_t data_in,
    output logic  busy,
    output logic  done,
    output logic  hit,
    output word_t data_out
);

    localparam int WAY_W = $clog2(`CACHE_WAYS);

    // tag store
    index_t             lookup_index;
    index_t             touch_index;
    index_t             fill_index;
    tag_t               lookup_tag;
    tag_t               fill_tag;
    tag_t               victim_tag;
    logic [WAY_W-1:0]   touch_way;
    logic [WAY_W-1:0]   fill_way;
    logic [WAY_W-1:0]   hit_way;
    logic [WAY_W-1:0]   victim_way;
    logic               touch;
    logic               mark_dirty;
    logic               fill;
    logic               lookup_hit;
    logic               victim_dirty;

    // data store
    logic [WAY_W-1:0]   rd_way;
    logic [WAY_W-1:0]   wr_way;
    index_t             rd_index;
    index_t             wr_index;
    offset_t            rd_offset;
    offset_t            wr_offset;
    logic               wr_en;
    word_t              wr_data;
    word_t              rd_data;

    // backing memory
    logic               mem_rd;
    logic               mem_wr;
    addr_t              mem_addr;
    word_t              mem_wdata;
    word_t              mem_rdata;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .rden         (rden),
        .wren         (wren),
        .addr         (addr),
        .data_in      (data_in),
        .busy         (busy),
        .done         (done),
        .hit          (hit),
        .data_out     (data_out),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .touch        (touch),
        .touch_index  (touch_index),
        .touch_way    (touch_way),
        .mark_dirty   (mark_dirty),
        .fill         (fill),
        .fill_index   (fill_index),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .lookup_hit   (lookup_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_way       (rd_way),
        .rd_index     (rd_index),
        .rd_offset    (rd_offset),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_index     (wr_index),
        .wr_offset    (wr_offset),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata)
    );

    cache_tag_store u_tag_store (
        .clk          (clk),
        .reset        (reset),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .touch        (touch),
        .touch_index  (touch_index),
        .touch_way    (touch_way),
        .mark_dirty   (mark_dirty),
        .fill         (fill),
        .fill_index   (fill_index),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .lookup_hit   (lookup_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_store u_data_store (
        .clk       (clk),
        .rd_way    (rd_way),
        .rd_index  (rd_index),
        .rd_offset (rd_offset),
        .wr_en     (wr_en),
        .wr_way    (wr_way),
        .wr_index  (wr_index),
        .wr_offset (wr_offset),
        .wr_data   (wr_data),
        .rd_data   (rd_data)
    );

    main_memory u_main_memory (
        .clk       (clk),
        .reset     (reset),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== design/main_memory.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module main_memory (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_rd,
    input  logic               mem_wr,
    input  logic [`ADDR_W-1:0] mem_addr,
    input  logic [`WORD_W-1:0] mem_wdata,
    output logic [`WORD_W-1:0] mem_rdata
);

    logic [`WORD_W-1:0] mem [`MEM_WORDS];

    // memory starts out all zero
    initial
    begin
        for (int i = 0; i < `MEM_WORDS; i++)
        begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_wr)
            mem[mem_addr] <= mem_wdata;
    end

    // read data is valid the cycle after mem_rd
    always_ff @(posedge clk)
    begin
        if (reset)
            mem_rdata <= '0;
        else if (mem_rd)
            mem_rdata <= mem[mem_addr];
    end

    assert property (@(posedge clk) disable iff (reset) !(mem_rd && mem_wr));

endmodule

// ==== design/cache_ctrl.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_ctrl
    import cache_addr_pkg::*;
    import cache_state_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    rden,
    input  logic    wren,
    input  addr_t   addr,
    input  word_t   data_in,
    output logic    busy,
    output logic    done,
    output logic    hit,
    output word_t   data_out,
    output index_t  lookup_index,
    output tag_t    lookup_tag,
    output logic    touch,
    output index_t  touch_index,
    output way_t    touch_way,
    output logic    mark_dirty,
    output logic    fill,
    output index_t  fill_index,
    output way_t    fill_way,
    output tag_t    fill_tag,
    input  logic    lookup_hit,
    input  way_t    hit_way,
    input  way_t    victim_way,
    input  logic    victim_dirty,
    input  tag_t    victim_tag,
    output way_t    rd_way,
    output index_t  rd_index,
    output offset_t rd_offset,
    output logic    wr_en,
    output way_t    wr_way,
    output index_t  wr_index,
    output offset_t wr_offset,
    output word_t   wr_data,
    input  word_t   rd_data,
    output logic    mem_rd,
    output logic    mem_wr,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    input  word_t   mem_rdata
);

    localparam offset_t LAST_WORD = offset_t'(`BLOCK_WORDS - 1);

    ctrl_state_t state;
    offset_t     cnt;
    logic        hit_r;
    logic        accept;

    // registered request
    addr_t       req_addr;
    word_t       req_data;
    logic        req_write;
    way_t        way_r;
    tag_t        victim_tag_r;

    tag_t        req_tag;
    index_t      req_index;
    offset_t     req_offset;
    block_addr_t req_blk;
    block_addr_t victim_blk;

    assign req_tag    = req_addr[`ADDR_W-1 -: `TAG_W];
    assign req_index  = req_addr[`OFFSET_W +: `INDEX_W];
    assign req_offset = req_addr[`OFFSET_W-1:0];
    assign req_blk    = {req_tag, req_index};
    assign victim_blk = {victim_tag_r, req_index};

    // a new request may follow directly on the done cycle
    assign accept = (rden || wren) && (state == IDLE || state == RESPOND);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            cnt   <= '0;
            hit_r <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (accept)
                        state <= LOOKUP;
                end
                LOOKUP:
                begin
                    hit_r <= lookup_hit;
                    cnt   <= '0;
                    if (lookup_hit)
                        state <= RESPOND;
                    else if (victim_dirty)
                        state <= WRITEBACK;
                    else
                        state <= REFILL;
                end
                WRITEBACK:
                begin
                    // counter wraps back to word 0 for the refill
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST_WORD)
                        state <= REFILL;
                end
                REFILL:
                begin
                    state <= REFILL_WAIT;
                end
                REFILL_WAIT:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST_WORD)
                        state <= RESPOND;
                    else
                        state <= REFILL;
                end
                RESPOND:
                begin
                    state <= accept ? LOOKUP : IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr  <= addr;
            req_data  <= data_in;
            req_write <= wren;
        end
        // way that serves the request, the hit way or the victim
        if (state == LOOKUP)
        begin
            way_r        <= lookup_hit ? hit_way : victim_way;
            victim_tag_r <= victim_tag;
        end
    end

    assign busy     = (state != IDLE) && (state != RESPOND);
    assign done     = (state == RESPOND);
    assign hit      = hit_r;
    assign data_out = req_write ? req_data : rd_data;

    assign lookup_index = req_index;
    assign lookup_tag   = req_tag;

    // age update and tag install both land on the done cycle
    assign touch       = done;
    assign touch_index = req_index;
    assign touch_way   = way_r;
    assign mark_dirty  = done && req_write;
    assign fill        = done && !hit_r;
    assign fill_index  = req_index;
    assign fill_way    = way_r;
    assign fill_tag    = req_tag;

    assign rd_way    = way_r;
    assign rd_index  = req_index;
    assign rd_offset = (state == WRITEBACK) ? cnt : req_offset;

    assign wr_en     = (state == REFILL_WAIT) || (done && req_write);
    assign wr_way    = way_r;
    assign wr_index  = req_index;
    assign wr_offset = (state == REFILL_WAIT) ? cnt : req_offset;
    assign wr_data   = (state == REFILL_WAIT) ? mem_rdata : req_data;

    assign mem_rd    = (state == REFILL);
    assign mem_wr    = (state == WRITEBACK);
    assign mem_addr  = (state == WRITEBACK) ? {victim_blk, cnt} : {req_blk, cnt};
    assign mem_wdata = rd_data;

    assert property (@(posedge clk) disable iff (reset) (rden || wren) |-> !busy);
    assert property (@(posedge clk) disable iff (reset) !(rden && wren));

endmodule

// ==== design/cache_data_store.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_data_store
    import cache_addr_pkg::*;
(
    input  logic                           clk,
    input  logic [$clog2(`CACHE_WAYS)-1:0] rd_way,
    input  index_t                         rd_index,
    input  offset_t                        rd_offset,
    input  logic                           wr_en,
    input  logic [$clog2(`CACHE_WAYS)-1:0] wr_way,
    input  index_t                         wr_index,
    input  offset_t                        wr_offset,
    input  word_t                          wr_data,
    output word_t                          rd_data
);

    // one word per way, set and offset
    word_t data [`CACHE_WAYS][`CACHE_SETS][`BLOCK_WORDS];

    // read is combinational so a hit can answer in the same cycle
    assign rd_data = data[rd_way][rd_index][rd_offset];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            data[wr_way][wr_index][wr_offset] <= wr_data;
    end

endmodule

// ==== design/cache_tag_store.sv ====
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_tag_store
    import cache_addr_pkg::*;
    import cache_state_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  index_t   lookup_index,
    input  tag_t     lookup_tag,
    input  logic     touch,
    input  index_t   touch_index,
    input  way_t     touch_way,
    input  logic     mark_dirty,
    input  logic     fill,
    input  index_t   fill_index,
    input  way_t     fill_way,
    input  tag_t     fill_tag,
    output logic     lookup_hit,
    output way_t     hit_way,
    output way_t     victim_way,
    output logic     victim_dirty,
    output tag_t     victim_tag
);

    localparam lru_age_t OLDEST = lru_age_t'(`CACHE_WAYS - 1);

    logic     valid [`CACHE_SETS][`CACHE_WAYS];
    logic     dirty [`CACHE_SETS][`CACHE_WAYS];
    tag_t     tags  [`CACHE_SETS][`CACHE_WAYS];
    lru_age_t age   [`CACHE_SETS][`CACHE_WAYS];

    logic [`CACHE_WAYS-1:0] match;
    lru_age_t               touch_old_age;

    // compare every way of the set in parallel
    always_comb
    begin
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            match[w] = valid[lookup_index][w] && (tags[lookup_index][w] == lookup_tag);
        end
    end

    assign lookup_hit = |match;

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (match[w])
                hit_way = way_t'(w);
        end
    end

    // oldest way unless an invalid one exists, lowest invalid wins
    always_comb
    begin
        victim_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (age[lookup_index][w] == OLDEST)
                victim_way = way_t'(w);
        end
        for (int w = `CACHE_WAYS - 1; w >= 0; w--)
        begin
            if (!valid[lookup_index][w])
                victim_way = way_t'(w);
        end
    end

    assign victim_dirty = valid[lookup_index][victim_way] && dirty[lookup_index][victim_way];
    assign victim_tag   = tags[lookup_index][victim_way];

    // an invalid way counts as oldest so the ages of a set stay a permutation
    assign touch_old_age = valid[touch_index][touch_way] ? age[touch_index][touch_way] : OLDEST;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < `CACHE_SETS; s++)
            begin
                for (int w = 0; w < `CACHE_WAYS; w++)
                begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                    age[s][w]   <= '0;
                end
            end
        end
        else
        begin
            if (fill)
            begin
                valid[fill_index][fill_way] <= 1'b1;
                dirty[fill_index][fill_way] <= 1'b0;
            end
            if (touch)
            begin
                for (int w = 0; w < `CACHE_WAYS; w++)
                begin
                    if (way_t'(w) == touch_way)
                        age[touch_index][w] <= '0;
                    else if (age[touch_index][w] < touch_old_age)
                        age[touch_index][w] <= age[touch_index][w] + 1'b1;
                end
                // a write on the same cycle as a fill still leaves the line dirty
                if (mark_dirty)
                    dirty[touch_index][touch_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill)
            tags[fill_index][fill_way] <= fill_tag;
    end

    // a tag can live in only one way of a set
    assert property (@(posedge clk) disable iff (reset) $onehot0(match));

endmodule

// ==== design/cache_state_pkg.sv ====
`include "cache_cfg.svh"

package cache_state_pkg;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

    // 0 is most recently used, CACHE_WAYS-1 is the oldest
    typedef logic [$clog2(`CACHE_WAYS)-1:0] lru_age_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        REFILL_WAIT,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== design/cache_addr_pkg.sv ====
`include "cache_cfg.svh"

package cache_addr_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    // fields of a word address
    typedef logic [`TAG_W-1:0]    tag_t;
    typedef logic [`INDEX_W-1:0]  index_t;
    typedef logic [`OFFSET_W-1:0] offset_t;

    // tag and index together name one block in memory
    typedef logic [`TAG_W+`INDEX_W-1:0] block_addr_t;

endpackage

// ==== include/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry
`define CACHE_WAYS  4
`define CACHE_SETS  4
`define BLOCK_WORDS 4

// data word and word address widths
`define WORD_W 32
`define ADDR_W 12

// address fields from msb down to lsb
`define TAG_W    8
`define INDEX_W  2
`define OFFSET_W 2

// backing memory depth in words
`define MEM_WORDS 4096

`endif
